// File: files.f
src/bpu_cfg_pkg.sv
src/bpu_types_pkg.sv
src/bpu_update_decode.sv
src/bpu_tables.sv
src/bpu_ras.sv
src/bpu_npc_select.sv
src/bpu_top.sv
tests/tb_bpu.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_bpu
FILELIST := files.f
BUILD    := obj_dir
LOG      := sim.log
FAIL_MSG := Finished with errors
PASS_MSG := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

// File: tests/tb_bpu.sv
// mirrors assume each correction echoes the history and counter a lookup showed, and only one is in flight
`default_nettype none

module tb_bpu;

    timeunit 1ns;
    timeprecision 1ps;

    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    localparam int TIMEOUT = 200;   // cycles allowed per wait

    logic         clk;
    logic         rst_n;
    logic         flush_i;
    addr_t        redirect_pc_i;
    bpu_correct_t correct_i;
    bpu_predict_t pred_o;
    logic         pred_valid_o;
    logic         pred_ready_i;

    // mirror state trained by the same rules as the predictor
    btb_entry_t           m_btb [2][BTB_DEPTH];
    hist_t                m_bht [2][BTB_DEPTH];
    scnt_t                m_pht [2][PHT_DEPTH];
    addr_t                m_ras [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] m_wr;
    logic [RAS_PTR_W-1:0] m_top;

    addr_t exp_pc;          // fetch pc the dut should show
    int    transfers = 0;
    int    errors = 0;

    bpu_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .correct_i     (correct_i),
        .pred_o        (pred_o),
        .pred_valid_o  (pred_valid_o),
        .pred_ready_i  (pred_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic btb_idx_t pair_hash(input addr_t pc);
        return pc[14:9] ^ pc[8:3];
    endfunction

    // expected prediction for one fetch pair from the mirrors
    function automatic bpu_predict_t expected_pred(input addr_t pc);
        bpu_predict_t p;
        btb_entry_t   e;
        hist_t        h;
        scnt_t        cnt;
        logic         hit;
        logic [1:0]   tk;
        addr_t        dest [2];
        p = '0;
        p.pc = pc;
        for (int s = 0; s < 2; s++) begin
            e   = m_btb[s][pair_hash(pc)];
            h   = m_bht[s][pair_hash(pc)];
            cnt = m_pht[s][{h, pc[7:3]}];
            hit = e.valid && (e.tag == pc[22:15]);
            tk[s]   = hit && ((e.br_type != BR_COND) || (cnt >= 2'd2));
            dest[s] = (e.br_type == BR_RET) ? m_ras[m_top] : e.target;
            p.br_type[s]     = hit ? e.br_type : BR_NONE;
            p.need_update[s] = !hit;
            p.scnt[s]        = cnt;
            p.history[s]     = h;
        end
        if (pc[2]) p.mask = 2'b10;          // slot 0 lies before the pc
        else if (tk[0]) p.mask = 2'b01;
        else p.mask = 2'b11;
        p.taken = tk & p.mask;
        if (p.taken[0]) p.target_pc = dest[0];
        else if (p.taken[1]) p.target_pc = dest[1];
        else p.target_pc = {pc[31:3] + 29'd1, 3'b000};
        return p;
    endfunction

    task automatic mirror_update(input bpu_correct_t c);
        logic     s;
        btb_idx_t idx;
        pht_idx_t pidx;
        s    = c.pc[2];
        idx  = pair_hash(c.pc);
        pidx = {c.history, c.pc[7:3]};   // history the prediction used
        if (c.type_miss || c.target_miss) begin
            m_btb[s][idx] = '{valid: 1'b1, tag: c.pc[22:15], target: c.target, br_type: c.br_type};
        end
        if (c.update) begin
            m_bht[s][idx] = c.type_miss ? hist_t'(c.taken) : {c.history[3:0], c.taken};
            if (c.taken) m_pht[s][pidx] = (c.scnt == 2'd3) ? 2'd3 : c.scnt + 2'd1;
            else m_pht[s][pidx] = (c.scnt == 2'd0) ? 2'd0 : c.scnt - 2'd1;
            if (c.br_type == BR_CALL) begin
                m_ras[m_wr] = c.pc + 32'd4;
                m_top       = m_wr;
                m_wr        = m_wr + 1'b1;
            end else if (c.br_type == BR_RET) begin
                m_wr  = m_top;
                m_top = m_top - 1'b1;
            end
        end
    endtask

    function automatic bpu_correct_t make_correct(input addr_t pc, input addr_t target,
            input br_type_e t, input logic taken, input logic miss, input logic upd);
        bpu_correct_t c;
        c = '0;
        c.pc        = pc;
        c.target    = target;
        c.br_type   = t;
        c.taken     = taken;
        c.type_miss = miss;
        c.update    = upd;
        c.history   = m_bht[pc[2]][pair_hash(pc)];     // echo of what a lookup shows
        c.scnt      = m_pht[pc[2]][{c.history, pc[7:3]}];
        return c;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic send_correct(input bpu_correct_t c);
        correct_i = c;
        step();
        correct_i = '0;
        mirror_update(c);   // tables took it at this edge
    endtask

    task automatic flush_to(input addr_t pc);
        flush_i       = 1'b1;
        redirect_pc_i = pc;
        step();
        flush_i = 1'b0;
    endtask

    task automatic wait_transfers(input int n);
        int goal;
        int cycles;
        goal   = transfers + n;
        cycles = 0;
        while (transfers < goal) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timed out waiting for %0d prediction transfers", n);
                $display("Finished with errors");
                $fatal(1, "transfer timeout");
            end
        end
        #1;
    endtask

    // mid-cycle compare sees valid and ready as the next edge will
    initial begin : compare
        bpu_predict_t exp_pred;
        bpu_predict_t last_pred;
        logic         held;
        logic         settled;
        held      = 1'b0;
        settled   = 1'b0;
        last_pred = '0;
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                exp_pc  = BPU_INIT_PC;
                held    = 1'b0;
                settled = 1'b0;
            end else begin
                // one edge out of reset is allowed before valid rises
                if (settled) check_val("pred_valid_o", 128'(pred_valid_o), 128'(1'b1));
                settled = 1'b1;
                if (pred_valid_o) begin
                    if (held) begin
                        check_val("pred_o under back-pressure", 128'(pred_o),
                                  128'(last_pred));
                    end
                    exp_pred = expected_pred(exp_pc);
                    check_val("pred_o.pc", 128'(pred_o.pc), 128'(exp_pred.pc));
                    check_val("pred_o.target_pc", 128'(pred_o.target_pc),
                              128'(exp_pred.target_pc));
                    check_val("pred_o", 128'(pred_o), 128'(exp_pred));
                    held = !pred_ready_i && !flush_i
                           && !(correct_i.update || correct_i.type_miss || correct_i.target_miss);
                    last_pred = pred_o;
                    if (flush_i) begin
                        exp_pc = redirect_pc_i;          // flush beats the transfer
                    end else if (pred_ready_i) begin
                        exp_pc = exp_pred.target_pc;
                        transfers++;
                    end
                end
            end
        end
    end

    initial begin : stimulus
        bpu_correct_t c;
        addr_t        pc;
        addr_t        tgt;
        void'($urandom(32'h1f8f02d3));
        rst_n         = 1'b0;
        flush_i       = 1'b0;
        redirect_pc_i = '0;
        correct_i     = '0;
        pred_ready_i  = 1'b1;
        foreach (m_btb[s, i]) m_btb[s][i] = '0;
        foreach (m_bht[s, i]) m_bht[s][i] = '0;
        foreach (m_pht[s, i]) m_pht[s][i] = '0;
        foreach (m_ras[i]) m_ras[i] = '0;
        m_wr  = '0;
        m_top = '1;
        repeat (16) step();
        check_val("pred_valid_o", 128'(pred_valid_o), 128'(1'b0));
        rst_n = 1'b1;

        // sequential fetch and then a redirect into slot 1
        wait_transfers(6);
        flush_to(32'h1c000124);
        check_val("pred_o.mask", 128'(pred_o.mask), 128'(2'b10));

        // jump training and a tag alias
        pc  = 32'h1c000200;
        tgt = 32'h1c004000;
        send_correct(make_correct(pc, tgt, BR_JUMP, 1'b1, 1'b1, 1'b1));
        flush_to(pc);
        check_val("pred_o.target_pc", 128'(pred_o.target_pc), 128'(tgt));
        check_val("pred_o.taken", 128'(pred_o.taken), 128'(2'b01));
        check_val("pred_o.need_update", 128'(pred_o.need_update[0]), 128'(1'b0));
        flush_to(pc ^ 32'h00008000);   // same index with another tag
        check_val("pred_o.need_update", 128'(pred_o.need_update[0]), 128'(1'b1));
        check_val("pred_o.target_pc", 128'(pred_o.target_pc), 128'((pc ^ 32'h00008000) + 32'd8));

        // always-taken conditional branch in slot 1 with counters fed back
        pc  = 32'h1c000304;
        tgt = 32'h1c000800;
        for (int k = 0; k < 10; k++) begin
            flush_to(pc);
            if (k == 1) check_val("pred_o.taken", 128'(pred_o.taken), 128'(2'b00));
            c         = make_correct(pc, tgt, BR_COND, 1'b1, k == 0, 1'b1);
            c.history = pred_o.history[1];
            c.scnt    = pred_o.scnt[1];
            send_correct(c);
        end
        flush_to(pc);
        check_val("pred_o.taken", 128'(pred_o.taken), 128'(2'b10));
        check_val("pred_o.target_pc", 128'(pred_o.target_pc), 128'(tgt));

        // nested calls with the return trained before any pop
        send_correct(make_correct(32'h1c000400, 32'h1c008000, BR_CALL, 1'b1, 1'b1, 1'b1));
        send_correct(make_correct(32'h1c000500, 32'h1c009000, BR_CALL, 1'b1, 1'b1, 1'b1));
        send_correct(make_correct(32'h1c000604, '0, BR_RET, 1'b1, 1'b1, 1'b0));
        flush_to(32'h1c000604);
        check_val("pred_o.target_pc", 128'(pred_o.target_pc), 128'(32'h1c000504));
        send_correct(make_correct(32'h1c000604, '0, BR_RET, 1'b1, 1'b0, 1'b1));
        flush_to(32'h1c000604);
        check_val("pred_o.target_pc", 128'(pred_o.target_pc), 128'(32'h1c000404));

        // both slots taken
        send_correct(make_correct(32'h1c000a00, 32'h1c00c000, BR_JUMP, 1'b1, 1'b1, 1'b1));
        send_correct(make_correct(32'h1c000a04, 32'h1c00d000, BR_JUMP, 1'b1, 1'b1, 1'b1));
        flush_to(32'h1c000a00);
        check_val("pred_o.mask", 128'(pred_o.mask), 128'(2'b01));
        check_val("pred_o.target_pc", 128'(pred_o.target_pc), 128'(32'h1c00c000));
        flush_to(32'h1c000a04);
        check_val("pred_o.target_pc", 128'(pred_o.target_pc), 128'(32'h1c00d000));

        // correction and flush while back-pressured
        pred_ready_i = 1'b0;
        repeat (5) step();
        send_correct(make_correct(pred_o.pc, 32'h1c00e000, BR_JUMP, 1'b1, 1'b1, 1'b1));
        repeat (3) step();
        flush_to(32'h1c000f00);
        check_val("pred_o.pc", 128'(pred_o.pc), 128'(32'h1c000f00));
        repeat (3) step();
        pred_ready_i = 1'b1;

        // random branches at random pcs
        for (int n = 0; n < 24; n++) begin
            pc  = $urandom() & 32'hfffffffc;
            tgt = $urandom() & 32'hfffffffc;
            c   = make_correct(pc, tgt, br_type_e'(3'($urandom_range(4, 1))),
                               1'($urandom_range(1, 0)), 1'b1, 1'b1);
            send_correct(c);
            flush_to(pc);
            wait_transfers(2);
        end

        wait_transfers(4);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/bpu_top.sv
// no speculative history or ras update; all training comes from correct_i and is seen one cycle later
`default_nettype none

module bpu_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           flush_i,
    input  bpu_cfg_pkg::addr_t            redirect_pc_i,
    input  bpu_types_pkg::bpu_correct_t   correct_i,
    output bpu_types_pkg::bpu_predict_t   pred_o,
    output logic                          pred_valid_o,
    input  wire                           pred_ready_i
);

    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    addr_t             pc_q;         // current fetch pair
    addr_t             npc;
    logic              valid_q;
    tbl_wr_t           wr;           // decoded correction
    btb_entry_t [1:0]  btb_rd;
    logic [1:0]        btb_hit;
    hist_t [1:0]       hist_rd;
    scnt_t [1:0]       scnt_rd;
    addr_t             ras_top;
    bpu_predict_t      sel_pred;

    // valid rises on the first edge out of reset and stays up
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
        end
    end

    // flush first, otherwise advance only on a transfer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= BPU_INIT_PC;
        end else if (flush_i) begin
            pc_q <= redirect_pc_i;
        end else if (valid_q && pred_ready_i) begin
            pc_q <= npc;
        end
    end

    bpu_update_decode u_decode (
        .correct_i (correct_i),
        .wr_o      (wr)
    );

    bpu_tables u_tables (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_i       (wr),
        .fetch_pc_i (pc_q),
        .btb_o      (btb_rd),
        .hit_o      (btb_hit),
        .hist_o     (hist_rd),
        .scnt_o     (scnt_rd)
    );

    bpu_ras u_ras (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (wr.ras_push),
        .pop_i   (wr.ras_pop),
        .wdata_i (wr.ras_wdata),
        .top_o   (ras_top)
    );

    bpu_npc_select u_select (
        .pc_i      (pc_q),
        .btb_i     (btb_rd),
        .hit_i     (btb_hit),
        .scnt_i    (scnt_rd),
        .hist_i    (hist_rd),
        .ras_top_i (ras_top),
        .pred_o    (sel_pred),
        .npc_o     (npc)
    );

    always_comb begin
        pred_o    = sel_pred;
        pred_o.pc = pc_q;   // select leaves the pc out
    end

    assign pred_valid_o = valid_q;

endmodule

`default_nettype wire

// File: src/bpu_npc_select.sv
// pc field of pred_o is left zero here; the top level inserts the fetch pc
`default_nettype none

module bpu_npc_select (
    input  bpu_cfg_pkg::addr_t               pc_i,
    input  bpu_types_pkg::btb_entry_t [1:0]  btb_i,
    input  wire [1:0]                        hit_i,
    input  bpu_cfg_pkg::scnt_t [1:0]         scnt_i,
    input  bpu_cfg_pkg::hist_t [1:0]         hist_i,
    input  bpu_cfg_pkg::addr_t               ras_top_i,
    output bpu_types_pkg::bpu_predict_t      pred_o,
    output bpu_cfg_pkg::addr_t               npc_o
);

    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    logic [1:0] raw_taken;   // per slot, before masking
    logic [1:0] mask;
    addr_t      seq_pc;      // next aligned pair
    addr_t      tgt [2];     // per-slot redirect

    // unconditional hits always jump, conditional ones follow the counter msb
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            raw_taken[i] = hit_i[i] && ((btb_i[i].br_type != BR_COND) || scnt_i[i][1]);
            tgt[i]       = (btb_i[i].br_type == BR_RET) ? ras_top_i : btb_i[i].target;
        end
    end

    assign seq_pc = {pc_i[31:3] + 29'd1, 3'b000};

    // slot 0 exists only for an aligned pc, a taken slot 0 kills slot 1
    assign mask[0] = !pc_i[2];
    assign mask[1] = !(mask[0] && raw_taken[0]);

    always_comb begin
        if (mask[0] && raw_taken[0]) begin
            npc_o = tgt[0];
        end else if (raw_taken[1]) begin
            npc_o = tgt[1];
        end else begin
            npc_o = seq_pc;   // fall through
        end
    end

    always_comb begin
        pred_o           = '0;
        pred_o.mask      = mask;
        pred_o.target_pc = npc_o;
        pred_o.taken     = raw_taken & mask;   // only slots that are fetched
        for (int i = 0; i < 2; i++) begin
            // a miss reports no branch
            pred_o.br_type[i]     = hit_i[i] ? btb_i[i].br_type : BR_NONE;
            pred_o.scnt[i]        = scnt_i[i];
            pred_o.history[i]     = hist_i[i];
            pred_o.need_update[i] = !hit_i[i];
        end
    end

endmodule

`default_nettype wire

// File: src/bpu_ras.sv
// no overflow or underflow guard; pointers wrap and the oldest return is overwritten
`default_nettype none

module bpu_ras (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 push_i,
    input  wire                 pop_i,
    input  bpu_cfg_pkg::addr_t  wdata_i,
    output bpu_cfg_pkg::addr_t  top_o
);

    import bpu_cfg_pkg::*;

    addr_t [RAS_DEPTH-1:0] stack_q;
    logic [RAS_PTR_W-1:0]  wr_ptr_q;    // next free entry
    logic [RAS_PTR_W-1:0]  top_ptr_q;   // most recent push

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stack_q   <= '0;          // empty stack predicts zero
            wr_ptr_q  <= '0;
            top_ptr_q <= '1;          // one below the write pointer
        end else if (push_i) begin    // push wins over a pop in the same cycle
            stack_q[wr_ptr_q] <= wdata_i;
            top_ptr_q         <= wr_ptr_q;
            wr_ptr_q          <= wr_ptr_q + 1'b1;
        end else if (pop_i) begin
            wr_ptr_q  <= top_ptr_q;   // popped slot is reused next
            top_ptr_q <= top_ptr_q - 1'b1;
        end
    end

    assign top_o = stack_q[top_ptr_q];

endmodule

`default_nettype wire

// File: src/bpu_tables.sv
// lookups are combinational on fetch_pc_i, writes land at the clock edge so a same-cycle read sees old data
`default_nettype none

module bpu_tables (
    input  wire                                clk,
    input  wire                                rst_n,
    input  bpu_types_pkg::tbl_wr_t             wr_i,
    input  bpu_cfg_pkg::addr_t                 fetch_pc_i,
    output bpu_types_pkg::btb_entry_t [1:0]    btb_o,
    output logic [1:0]                         hit_o,
    output bpu_cfg_pkg::hist_t [1:0]           hist_o,
    output bpu_cfg_pkg::scnt_t [1:0]           scnt_o
);

    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    btb_idx_t rd_idx;   // same hash for btb and bht
    tag_t     rd_tag;

    assign rd_idx = btb_hash(fetch_pc_i);
    assign rd_tag = pc_tag(fetch_pc_i);

    // one bank per slot, bank b holds branches with pc[2] == b
    for (genvar b = 0; b < 2; b++) begin : g_bank

        btb_entry_t            btb_q [BTB_DEPTH];   // target, tag, type
        logic [BTB_DEPTH-1:0]  vld_q;               // valid bits kept apart, cleared on reset
        hist_t [BTB_DEPTH-1:0] bht_q;
        scnt_t [PHT_DEPTH-1:0] pht_q;
        logic                  bank_sel;
        btb_entry_t            rd_entry;
        hist_t                 rd_hist;
        pht_idx_t              pht_ridx;

        assign bank_sel = (wr_i.slot == 1'(b));

        // btb payload, no reset needed behind the valid bits
        always_ff @(posedge clk) begin
            if (wr_i.btb_we && bank_sel) begin
                btb_q[wr_i.btb_idx] <= wr_i.btb_entry;
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                vld_q <= '0;
            end else if (wr_i.btb_we && bank_sel) begin
                vld_q[wr_i.btb_idx] <= wr_i.btb_entry.valid;
            end
        end

        // local histories
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                bht_q <= '0;
            end else if (wr_i.bht_we && bank_sel) begin
                bht_q[wr_i.btb_idx] <= wr_i.bht_hist;
            end
        end

        // pattern counters, all start strongly not taken
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                pht_q <= '0;
            end else if (wr_i.pht_we && bank_sel) begin
                pht_q[wr_i.pht_idx] <= wr_i.pht_scnt;
            end
        end

        // read side
        always_comb begin
            rd_entry       = btb_q[rd_idx];
            rd_entry.valid = vld_q[rd_idx];   // stored copy of valid is not trusted
        end

        assign rd_hist  = bht_q[rd_idx];
        assign pht_ridx = pht_index(rd_hist, fetch_pc_i);   // this slot's own history

        assign btb_o[b]  = rd_entry;
        assign hit_o[b]  = rd_entry.valid && (rd_entry.tag == rd_tag);
        assign hist_o[b] = rd_hist;
        assign scnt_o[b] = pht_q[pht_ridx];
    end

endmodule

`default_nettype wire

// File: src/bpu_update_decode.sv
// combinational only; counters step from the echoed scnt, so the stored value is never read back here
`default_nettype none

module bpu_update_decode (
    input  bpu_types_pkg::bpu_correct_t correct_i,
    output bpu_types_pkg::tbl_wr_t      wr_o
);

    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    hist_t new_hist;    // history after this outcome
    scnt_t new_scnt;    // counter after one step

    // type miss means a branch never seen before, start a fresh history
    always_comb begin
        if (correct_i.type_miss) begin
            new_hist = {{(HIST_W-1){1'b0}}, correct_i.taken};
        end else begin
            new_hist = {correct_i.history[HIST_W-2:0], correct_i.taken};   // shift in at bottom
        end
    end

    // saturate at 0 and 3
    always_comb begin
        new_scnt = correct_i.scnt;
        if (correct_i.taken) begin
            if (correct_i.scnt != 2'd3) begin
                new_scnt = scnt_t'(correct_i.scnt + 2'd1);
            end
        end else if (correct_i.scnt != 2'd0) begin
            new_scnt = scnt_t'(correct_i.scnt - 2'd1);
        end
    end

    always_comb begin
        wr_o.slot              = correct_i.pc[2];
        // btb learns on any type or target mismatch
        wr_o.btb_we            = correct_i.type_miss | correct_i.target_miss;
        wr_o.btb_idx           = btb_hash(correct_i.pc);
        wr_o.btb_entry.valid   = 1'b1;
        wr_o.btb_entry.tag     = pc_tag(correct_i.pc);
        wr_o.btb_entry.target  = correct_i.target;
        wr_o.btb_entry.br_type = correct_i.br_type;

        wr_o.bht_we   = correct_i.update;
        wr_o.bht_hist = new_hist;

        // pattern slot chosen by the history the prediction used
        wr_o.pht_we   = correct_i.update;
        wr_o.pht_idx  = pht_index(correct_i.history, correct_i.pc);
        wr_o.pht_scnt = new_scnt;

        wr_o.ras_push  = correct_i.update && (correct_i.br_type == BR_CALL);
        wr_o.ras_pop   = correct_i.update && (correct_i.br_type == BR_RET);
        wr_o.ras_wdata = correct_i.pc + 32'd4;   // return lands after the call
    end

endmodule

`default_nettype wire

// File: src/bpu_types_pkg.sv
// per-slot prediction fields are two-entry arrays indexed by pc[2], and correction history and scnt must echo a prediction
`default_nettype none

package bpu_types_pkg;

    import bpu_cfg_pkg::*;

    // call and ret stay apart because they steer the ras
    typedef enum logic [2:0] {
        BR_NONE,
        BR_COND,
        BR_JUMP,
        BR_CALL,
        BR_RET
    } br_type_e;

    typedef struct packed {
        logic     valid;
        tag_t     tag;
        addr_t    target;
        br_type_e br_type;
    } btb_entry_t;

    // one prediction per fetch pair
    typedef struct packed {
        addr_t              pc;
        logic [1:0]         mask;          // slot valid bits
        addr_t              target_pc;     // predicted next pc
        br_type_e [1:0]     br_type;
        logic [1:0]         taken;
        scnt_t [1:0]        scnt;          // counter as read and fed back later
        hist_t [1:0]        history;       // history as read and fed back later
        logic [1:0]         need_update;   // btb miss
    } bpu_predict_t;

    // one-cycle backend correction strobe
    typedef struct packed {
        addr_t    pc;
        addr_t    target;
        br_type_e br_type;
        logic     taken;
        hist_t    history;
        scnt_t    scnt;
        logic     type_miss;
        logic     target_miss;
        logic     update;
    } bpu_correct_t;

    // decoded write commands for the tables and the stack
    typedef struct packed {
        logic       slot;           // pc[2] of the corrected branch
        logic       btb_we;
        btb_idx_t   btb_idx;        // also the bht index
        btb_entry_t btb_entry;
        logic       bht_we;
        hist_t      bht_hist;
        logic       pht_we;
        pht_idx_t   pht_idx;
        scnt_t      pht_scnt;
        logic       ras_push;
        logic       ras_pop;
        addr_t      ras_wdata;
    } tbl_wr_t;

endpackage

`default_nettype wire

// File: src/bpu_cfg_pkg.sv
// fixed table geometry; the hash, tag and pattern slices assume 8-byte fetch pairs and 32-bit pcs
`default_nettype none

package bpu_cfg_pkg;

    localparam int ADDR_W = 32;

    localparam logic [ADDR_W-1:0] BPU_INIT_PC = 32'h1c000000;   // first fetch after reset

    localparam int BTB_IDX_W = 6;                  // btb and bht share this index
    localparam int BTB_DEPTH = 1 << BTB_IDX_W;     // entries per bank
    localparam int TAG_W     = 8;                  // pc[22:15]
    localparam int HIST_W    = 5;                  // local history per branch
    localparam int PHT_PC_W  = 5;                  // pc[7:3] in the pattern index
    localparam int PHT_IDX_W = HIST_W + PHT_PC_W;
    localparam int PHT_DEPTH = 1 << PHT_IDX_W;     // counters per bank
    localparam int RAS_DEPTH = 8;
    localparam int RAS_PTR_W = 3;

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [HIST_W-1:0]    hist_t;
    typedef logic [PHT_IDX_W-1:0] pht_idx_t;
    typedef logic [1:0]           scnt_t;         // 2-bit saturating counter

    // fold pc[14:9] onto pc[8:3]
    function automatic btb_idx_t btb_hash(input addr_t pc);
        return pc[BTB_IDX_W+8:9] ^ pc[BTB_IDX_W+2:3];
    endfunction

    function automatic tag_t pc_tag(input addr_t pc);
        return pc[TAG_W+14:15];   // bits just above the hash window
    endfunction

    // history in the upper bits, pair address below
    function automatic pht_idx_t pht_index(input hist_t hist, input addr_t pc);
        return {hist, pc[PHT_PC_W+2:3]};
    endfunction

endpackage

`default_nettype wire
